// File: common/rob_alloc_if.sv
`timescale 1ns/10ps

// Dispatch group handoff between the producer and the ROB storage
interface rob_alloc_if;
	import rob_pkg::*;

	// One cycle strobe, there is no handshake back
	logic       alloc;
	rob_group_t ops;

	// Current tail and the full warning as seen by the producer
	rob_ndx_t   tail;
	logic       full;

	modport producer (
		output alloc,
		output ops,
		input  tail,
		input  full
	);

	modport buffer (
		input  alloc,
		input  ops,
		output tail,
		output full
	);

endinterface

// File: common/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// ==========================================================================
// ROB sizing
// ==========================================================================

// Number of entries in the reorder buffer
`define ROB_ENTRIES 16

// Entries per dispatch group and per retire group
`define GROUP_SIZE 4

// Width of the instruction tag carried in each entry
`define TAG_BITS 8

`endif

// File: common/rob_pkg.sv
`include "rob_defs.svh"

// ==========================================================================
// Shared ROB types
// ==========================================================================

package rob_pkg;

	// Position inside the ROB, wraps naturally at ROB_ENTRIES
	typedef logic [$clog2(`ROB_ENTRIES)-1:0] rob_ndx_t;

	// What dispatch hands over for one instruction
	// The hwi flag marks an instruction that carries a hardware interrupt
	typedef struct packed {
		logic [`TAG_BITS-1:0] tag;
		logic                 hwi;
	} rob_op_t;

	// One ROB slot
	// Valid is set at allocation and cleared at retirement or when a stomp
	// pulls the tail back over the slot
	// Done comes from execution, stomped from a branch miss
	typedef struct packed {
		rob_op_t op;
		logic    valid;
		logic    done;
		logic    stomped;
	} rob_entry_t;

	// A full dispatch group, slot 0 is the oldest instruction
	typedef rob_op_t [`GROUP_SIZE-1:0] rob_group_t;

endpackage

// File: design/commit_retire.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

// ==========================================================================
// Retirement of the head group
// ==========================================================================

module commit_retire (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  rob_pkg::rob_entry_t [`GROUP_SIZE-1:0] head_group,
	input  logic                                  release_strobe,
	output logic                                  retire_strobe,
	output logic [`GROUP_SIZE-1:0]                retire_mask,
	output logic [`GROUP_SIZE*`TAG_BITS-1:0]      retire_tags
);

	// Strobe lasts one cycle per released group
	always_ff @(posedge clk) begin
		if (!rst_n)
			retire_strobe <= 1'b0;
		else
			retire_strobe <= release_strobe;
	end

	// Only entries that were not stomped really retire
	// Tag of slot 0 sits in the lowest byte of retire_tags
	always_ff @(posedge clk) begin
		if (release_strobe) begin
			for (int i = 0; i < `GROUP_SIZE; i++) begin
				retire_mask[i] <= !head_group[i].stomped;
				retire_tags[i*`TAG_BITS +: `TAG_BITS] <= head_group[i].op.tag;
			end
		end
	end

endmodule

// File: design/dispatch_alloc.sv
`timescale 1ns/10ps

// ==========================================================================
// Dispatch side of the ROB
// ==========================================================================

module dispatch_alloc (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                disp_strobe,
	input  rob_pkg::rob_group_t disp_ops,
	rob_alloc_if.producer       alloc_bus,
	output logic                full
);
	import rob_pkg::*;

	logic       accept;
	logic       stage_valid;
	rob_group_t stage_ops;

	// Nothing is queued here and a strobe against a full ROB is gone
	assign accept = disp_strobe && !alloc_bus.full;

	// A single stage holds at most one group in flight
	always_ff @(posedge clk) begin
		if (!rst_n)
			stage_valid <= 1'b0;
		else
			stage_valid <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept)
			stage_ops <= disp_ops;
	end

	assign alloc_bus.alloc = stage_valid;
	assign alloc_bus.ops = stage_ops;

	assign full = alloc_bus.full;

endmodule

// File: design/rob_top.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

// ==========================================================================
// ROB slice top level
// ==========================================================================

module rob_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             disp_strobe,
	input  rob_pkg::rob_group_t              disp_ops,
	input  logic                             done_strobe,
	input  rob_pkg::rob_ndx_t                done_ndx,
	input  logic                             stomp_strobe,
	input  rob_pkg::rob_ndx_t                stomp_ndx,
	output logic                             full,
	output logic                             retire_strobe,
	output logic [`GROUP_SIZE-1:0]           retire_mask,
	output logic [`GROUP_SIZE*`TAG_BITS-1:0] retire_tags,
	output rob_pkg::rob_ndx_t                tail
);
	import rob_pkg::*;

	rob_alloc_if alloc_bus ();

	rob_entry_t [`GROUP_SIZE-1:0] head_group;
	logic                         release_strobe;

	// Producer stage in front of the buffer
	dispatch_alloc dispatch_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.disp_strobe (disp_strobe),
		.disp_ops    (disp_ops),
		.alloc_bus   (alloc_bus),
		.full        (full)
	);

	rob_buffer buffer_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.alloc_bus      (alloc_bus),
		.done_strobe    (done_strobe),
		.done_ndx       (done_ndx),
		.stomp_strobe   (stomp_strobe),
		.stomp_ndx      (stomp_ndx),
		.head_group     (head_group),
		.release_strobe (release_strobe)
	);

	commit_retire retire_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.head_group     (head_group),
		.release_strobe (release_strobe),
		.retire_strobe  (retire_strobe),
		.retire_mask    (retire_mask),
		.retire_tags    (retire_tags)
	);

	// Tail as the producer sees it
	assign tail = alloc_bus.tail;

endmodule

// File: rob/rob_buffer.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

// ==========================================================================
// ROB storage with head and tail pointers
// ==========================================================================

module rob_buffer (
	input  logic                                  clk,
	input  logic                                  rst_n,
	rob_alloc_if.buffer                           alloc_bus,
	input  logic                                  done_strobe,
	input  rob_pkg::rob_ndx_t                     done_ndx,
	input  logic                                  stomp_strobe,
	input  rob_pkg::rob_ndx_t                     stomp_ndx,
	output rob_pkg::rob_entry_t [`GROUP_SIZE-1:0] head_group,
	output logic                                  release_strobe
);
	import rob_pkg::*;

	localparam int GROUPS = `ROB_ENTRIES / `GROUP_SIZE;
	localparam int CNT_BITS = $clog2(GROUPS) + 1;

	rob_entry_t [`ROB_ENTRIES-1:0] rob;
	rob_ndx_t                      head;
	rob_ndx_t                      tail;
	// Groups currently allocated, zero up to GROUPS
	logic [CNT_BITS-1:0]           grp_count;
	logic                          room;
	logic                          full;
	logic                          do_alloc;
	logic [`ROB_ENTRIES-1:0]       stomp_mask;
	rob_ndx_t                      stail;
	// Slots between the new tail and the old one, dropped by a stomp
	rob_ndx_t                      trim_span;
	logic [CNT_BITS-1:0]           trim_groups;

	// ======================================================================
	// Occupancy
	// ======================================================================

	assign room = grp_count < CNT_BITS'(GROUPS);

	// Full also counts the group waiting in the producer stage, so the
	// outside world sees it one edge before the tail actually wraps
	assign full = !room || (grp_count == CNT_BITS'(GROUPS - 1) && alloc_bus.alloc);

	// A stomp in the same cycle kills the incoming group since it is younger
	// than the mispredicted branch
	assign do_alloc = alloc_bus.alloc && room && !stomp_strobe;

	assign alloc_bus.full = full;
	assign alloc_bus.tail = tail;

	// ======================================================================
	// Stomp range and new tail
	// ======================================================================

	// Mark valid entries from stomp_ndx up to the slot before the tail
	// When the ROB is completely full the range wraps all the way round
	always_comb begin
		rob_ndx_t dist_n;
		rob_ndx_t dist_t;
		dist_t = tail - stomp_ndx;
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			dist_n = rob_ndx_t'(n) - stomp_ndx;
			stomp_mask[n] = stomp_strobe && rob[n].valid &&
				(dist_n < dist_t || (dist_t == '0 && !room));
		end
	end

	rob_stail stail_inst (
		.head0          (head),
		.tail0          (tail),
		.robentry_stomp (stomp_mask),
		.rob            (rob),
		.stail          (stail)
	);

	assign trim_span = tail - stail;
	assign trim_groups = CNT_BITS'(trim_span >> $clog2(`GROUP_SIZE));

	// ======================================================================
	// Head group and release
	// ======================================================================

	// The head is always group aligned, so the head group never wraps
	always_comb begin
		release_strobe = 1'b1;
		for (int i = 0; i < `GROUP_SIZE; i++) begin
			head_group[i] = rob[head + rob_ndx_t'(i)];
			release_strobe &= head_group[i].valid &&
				(head_group[i].done || head_group[i].stomped);
		end
	end

	// ======================================================================
	// Entry and pointer update
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			grp_count <= '0;
			for (int n = 0; n < `ROB_ENTRIES; n++) begin
				rob[n].valid <= 1'b0;
				rob[n].done <= 1'b0;
				rob[n].stomped <= 1'b0;
			end
		end else begin
			// New group lands at the tail with fresh status
			if (do_alloc) begin
				for (int i = 0; i < `GROUP_SIZE; i++) begin
					rob[tail + rob_ndx_t'(i)].op <= alloc_bus.ops[i];
					rob[tail + rob_ndx_t'(i)].valid <= 1'b1;
					rob[tail + rob_ndx_t'(i)].done <= 1'b0;
					rob[tail + rob_ndx_t'(i)].stomped <= 1'b0;
				end
				tail <= tail + rob_ndx_t'(`GROUP_SIZE);
			end

			if (done_strobe)
				rob[done_ndx].done <= 1'b1;

			// Stomped slots stay behind the new tail and retire masked out
			// The ones past it are simply given back
			if (stomp_strobe) begin
				for (int n = 0; n < `ROB_ENTRIES; n++) begin
					if (stomp_mask[n])
						rob[n].stomped <= 1'b1;
					if (rob_ndx_t'(rob_ndx_t'(n) - stail) < trim_span)
						rob[n].valid <= 1'b0;
				end
				tail <= stail;
			end

			if (release_strobe) begin
				for (int i = 0; i < `GROUP_SIZE; i++)
					rob[head + rob_ndx_t'(i)].valid <= 1'b0;
				head <= head + rob_ndx_t'(`GROUP_SIZE);
			end

			grp_count <= grp_count + CNT_BITS'(do_alloc) - CNT_BITS'(release_strobe)
				- (stomp_strobe ? trim_groups : '0);
		end
	end

endmodule

// File: rob/rob_stail.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

// ==========================================================================
// Tail position after a branch stomp
// ==========================================================================

module rob_stail (
	input  rob_pkg::rob_ndx_t                     head0,
	input  rob_pkg::rob_ndx_t                     tail0,
	input  logic [`ROB_ENTRIES-1:0]               robentry_stomp,
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] rob,
	output rob_pkg::rob_ndx_t                     stail
);
	import rob_pkg::*;

	// Low index bits that select a slot inside a group
	localparam rob_ndx_t GROUP_MASK = rob_ndx_t'(`GROUP_SIZE - 1);

	logic     hwi_pending;
	logic     found;
	rob_ndx_t pos;
	rob_ndx_t prev;

	// An interrupt anywhere in flight pins the tail where it is
	always_comb begin
		hwi_pending = 1'b0;
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			if (rob[n].valid && rob[n].op.hwi)
				hwi_pending = 1'b1;
		end
	end

	// Walk the ring from the oldest entry and stop at the first slot where
	// the stomp mask turns on
	// That slot's group boundary (rounded up) becomes the new tail
	always_comb begin
		found = 1'b0;
		stail = tail0;
		pos = head0;
		prev = head0;
		for (int i = 0; i < `ROB_ENTRIES; i++) begin
			pos = head0 + rob_ndx_t'(i);
			prev = pos - 1'b1;
			if (!hwi_pending && !found && robentry_stomp[pos] && !robentry_stomp[prev]) begin
				stail = (pos + GROUP_MASK) & ~GROUP_MASK;
				found = 1'b1;
			end
		end
	end

endmodule

// File: tb/rob_asserts.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

// ==========================================================================
// Pointer and release properties of the ROB storage
// ==========================================================================

module rob_asserts (
	input logic                                       clk,
	input logic                                       rst_n,
	input rob_pkg::rob_ndx_t                          head,
	input rob_pkg::rob_ndx_t                          tail,
	input logic [$clog2(`ROB_ENTRIES/`GROUP_SIZE):0]  grp_count,
	input logic                                       release_strobe
);
	import rob_pkg::*;

	localparam rob_ndx_t GROUP_MASK = rob_ndx_t'(`GROUP_SIZE - 1);

	// Tail moves by whole groups even when a stomp pulls it back
	tail_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(tail & GROUP_MASK) == '0)
	else $error("tail is not on a group boundary");

	// A released head group must be one that is still counted as allocated
	// Stale valid bits left behind a stomped tail would trip this
	release_valid: assert property (@(posedge clk) disable iff (!rst_n)
		release_strobe |-> grp_count != '0)
	else $error("release of a head group that is not allocated");

	// Ring distance from head to tail always equals the allocated groups
	// so the head can never run past the tail
	head_behind_tail: assert property (@(posedge clk) disable iff (!rst_n)
		rob_ndx_t'(tail - head) == rob_ndx_t'(grp_count * `GROUP_SIZE))
	else $error("head and tail disagree with the group count");

endmodule

bind rob_buffer rob_asserts asserts_inst (
	.clk            (clk),
	.rst_n          (rst_n),
	.head           (head),
	.tail           (tail),
	.grp_count      (grp_count),
	.release_strobe (release_strobe)
);

// File: tb/rob_tb.sv
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_tb;
	import rob_pkg::*;

	localparam int N_ENTRIES = `ROB_ENTRIES;
	localparam int GSIZE = `GROUP_SIZE;
	localparam int N_GROUPS = N_ENTRIES / GSIZE;
	localparam int N_DIRECTED = 21;
	localparam int N_RANDOM = 80;
	localparam int N_STEPS = N_DIRECTED + N_RANDOM;
	localparam int WATCHDOG_CYCLES = N_STEPS * 4 + 20;

	localparam logic [1:0] K_DISP = 2'd0;
	localparam logic [1:0] K_DONE = 2'd1;
	localparam logic [1:0] K_STOMP = 2'd2;

	// For done and stomp the index is an offset from the current head
	typedef struct packed {
		logic [1:0]  kind;
		logic [4:0]  ndx;
		logic [31:0] seed;
		logic        hwi;
	} step_t;

	typedef struct packed {
		logic [`GROUP_SIZE-1:0]           mask;
		logic [`GROUP_SIZE*`TAG_BITS-1:0] tags;
	} retire_t;

	logic                             clk;
	logic                             rst_n;
	logic                             disp_strobe;
	rob_group_t                       disp_ops;
	logic                             done_strobe;
	rob_ndx_t                         done_ndx;
	logic                             stomp_strobe;
	rob_ndx_t                         stomp_ndx;
	logic                             full;
	logic                             retire_strobe;
	logic [`GROUP_SIZE-1:0]           retire_mask;
	logic [`GROUP_SIZE*`TAG_BITS-1:0] retire_tags;
	rob_ndx_t                         tail;

	step_t   steps [N_STEPS];
	retire_t exp_q [$];
	int      errors = 0;
	int      checks = 0;

	// Behavioral copy of the ROB state
	logic [`TAG_BITS-1:0] m_tag [N_ENTRIES];
	logic m_hwi [N_ENTRIES];
	logic m_valid [N_ENTRIES];
	logic m_done [N_ENTRIES];
	logic m_stomped [N_ENTRIES];
	int   m_head;
	int   m_tail;
	int   m_groups;

	rob_top rob_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.disp_strobe   (disp_strobe),
		.disp_ops      (disp_ops),
		.done_strobe   (done_strobe),
		.done_ndx      (done_ndx),
		.stomp_strobe  (stomp_strobe),
		.stomp_ndx     (stomp_ndx),
		.full          (full),
		.retire_strobe (retire_strobe),
		.retire_mask   (retire_mask),
		.retire_tags   (retire_tags),
		.tail          (tail)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int wrap(input int n);
		return n & (N_ENTRIES - 1);
	endfunction

	function automatic step_t make_step(input logic [1:0] kind, input int ndx,
			input logic [31:0] seed, input logic hwi);
		step_t st;
		st.kind = kind;
		st.ndx = ndx[4:0];
		st.seed = seed;
		st.hwi = hwi;
		return st;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================

	// Retire every complete group at the head and queue one expected record
	// for each of them
	task automatic retire_complete_groups(output int released);
		logic    complete;
		retire_t rec;
		int      e;
		released = 0;
		complete = 1'b1;
		while (complete) begin
			for (int i = 0; i < GSIZE; i++) begin
				e = wrap(m_head + i);
				if (!m_valid[e] || !(m_done[e] || m_stomped[e]))
					complete = 1'b0;
				rec.mask[i] = !m_stomped[e];
				rec.tags[i*`TAG_BITS +: `TAG_BITS] = m_tag[e];
			end
			if (complete) begin
				for (int i = 0; i < GSIZE; i++)
					m_valid[wrap(m_head + i)] = 1'b0;
				m_head = wrap(m_head + GSIZE);
				m_groups--;
				released++;
				exp_q.push_back(rec);
			end
		end
	endtask

	// A group against a full ROB is lost
	task automatic allocate_group(input rob_group_t ops);
		int e;
		if (m_groups < N_GROUPS) begin
			for (int i = 0; i < GSIZE; i++) begin
				e = wrap(m_tail + i);
				m_tag[e] = ops[i].tag;
				m_hwi[e] = ops[i].hwi;
				m_valid[e] = 1'b1;
				m_done[e] = 1'b0;
				m_stomped[e] = 1'b0;
			end
			m_tail = wrap(m_tail + GSIZE);
			m_groups++;
		end
	endtask

	// Stomp from ndx to the tail, then pull the tail back to the next group
	// boundary unless an interrupt is in flight
	task automatic stomp_to_tail(input int ndx);
		logic hwi_pending;
		int   span;
		int   new_tail;
		int   trim;
		hwi_pending = 1'b0;
		for (int n = 0; n < N_ENTRIES; n++)
			if (m_valid[n] && m_hwi[n])
				hwi_pending = 1'b1;
		span = wrap(m_tail - ndx);
		for (int k = 0; k < span; k++)
			if (m_valid[wrap(ndx + k)])
				m_stomped[wrap(ndx + k)] = 1'b1;
		if (!hwi_pending) begin
			new_tail = wrap((ndx + GSIZE - 1) & ~(GSIZE - 1));
			trim = wrap(m_tail - new_tail);
			for (int k = 0; k < trim; k++)
				m_valid[wrap(new_tail + k)] = 1'b0;
			m_groups -= trim / GSIZE;
			m_tail = new_tail;
		end
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================

	task automatic apply_step(input step_t st);
		rob_group_t  ops;
		logic [31:0] word;
		logic [1:0]  kind;
		int          occupied;
		int          off;
		int          released;
		occupied = m_groups * GSIZE;
		kind = (occupied == 0) ? K_DISP : st.kind;
		word = xorshift32(st.seed);
		for (int i = 0; i < GSIZE; i++) begin
			ops[i].tag = word[i*`TAG_BITS +: `TAG_BITS];
			ops[i].hwi = (i == 0) && st.hwi;
		end
		@(posedge clk);
		if (kind == K_DISP) begin
			disp_strobe <= 1'b1;
			disp_ops <= ops;
		end else if (kind == K_DONE) begin
			off = int'(st.ndx) % occupied;
			done_strobe <= 1'b1;
			done_ndx <= rob_ndx_t'(wrap(m_head + off));
		end else begin
			// Never at the head itself so that head and tail cannot collide
			off = int'(st.ndx) % occupied;
			if (off == 0)
				off = 1;
			stomp_strobe <= 1'b1;
			stomp_ndx <= rob_ndx_t'(wrap(m_head + off));
		end
		@(posedge clk);
		disp_strobe <= 1'b0;
		done_strobe <= 1'b0;
		stomp_strobe <= 1'b0;
		if (kind == K_DISP)
			allocate_group(ops);
		else if (kind == K_DONE)
			m_done[wrap(m_head + off)] = 1'b1;
		else
			stomp_to_tail(wrap(m_head + off));
		retire_complete_groups(released);
		// One edge for the write or the first release and one more for each
		// chained group
		repeat (1 + released) @(posedge clk);
		@(negedge clk);
		check_value("tail", tail, m_tail);
		check_value("full", full, m_groups == N_GROUPS);
	endtask

	// Each retire_strobe must match the oldest expected retirement
	always @(negedge clk) begin
		if (rst_n && retire_strobe === 1'b1) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("retire_strobe rose at %0t with no retirement expected", $time);
			end
			if (exp_q.size() != 0) begin
				check_value("retire_mask", retire_mask, exp_q[0].mask);
				check_value("retire_tags", retire_tags, exp_q[0].tags);
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rng;
		logic [1:0]  kind;
		rst_n = 1'b0;
		disp_strobe = 1'b0;
		disp_ops = '0;
		done_strobe = 1'b0;
		done_ndx = '0;
		stomp_strobe = 1'b0;
		stomp_ndx = '0;
		m_head = 0;
		m_tail = 0;
		m_groups = 0;
		for (int n = 0; n < N_ENTRIES; n++) begin
			m_valid[n] = 1'b0;
			m_hwi[n] = 1'b0;
			m_done[n] = 1'b0;
			m_stomped[n] = 1'b0;
			m_tag[n] = '0;
		end

		// Fill the ROB and then send one group that has to be dropped
		for (int s = 0; s < 5; s++)
			steps[s] = make_step(K_DISP, 0, 32'h0000_1111 * (s + 1), 1'b0);
		// Complete the head group
		for (int s = 5; s < 9; s++)
			steps[s] = make_step(K_DONE, s - 5, '0, 1'b0);
		// A stomp in the middle of the third group moves the tail to the
		// next group boundary
		steps[9] = make_step(K_STOMP, 6, '0, 1'b0);
		for (int s = 10; s < 14; s++)
			steps[s] = make_step(K_DONE, s - 10, '0, 1'b0);
		steps[14] = make_step(K_DONE, 0, '0, 1'b0);
		steps[15] = make_step(K_DONE, 1, '0, 1'b0);
		// Interrupt in flight pins the tail during the stomp
		steps[16] = make_step(K_DISP, 0, 32'h0000_6666, 1'b1);
		steps[17] = make_step(K_DISP, 0, 32'h0000_7777, 1'b0);
		steps[18] = make_step(K_STOMP, 2, '0, 1'b0);
		steps[19] = make_step(K_DONE, 0, '0, 1'b0);
		steps[20] = make_step(K_DONE, 1, '0, 1'b0);

		// Random mix weighted towards dones so groups keep retiring
		rng = 32'hf2d361e9;
		for (int s = N_DIRECTED; s < N_STEPS; s++) begin
			rng = xorshift32(rng);
			if (rng[3:0] < 4'd5)
				kind = K_DISP;
			else if (rng[3:0] < 4'd14)
				kind = K_DONE;
			else
				kind = K_STOMP;
			steps[s] = make_step(kind, int'(rng[8:4]), xorshift32(rng ^ 32'h5a5a_5a5a),
				rng[13:9] == 5'd0);
		end

		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("tail", tail, 0);
		check_value("full", full, 0);
		check_value("retire_strobe", retire_strobe, 0);

		for (int s = 0; s < N_STEPS; s++)
			apply_step(steps[s]);

		assert (exp_q.size() == 0) else begin
			errors++;
			$display("%0d expected retirements never happened", exp_q.size());
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+common
common/rob_pkg.sv
common/rob_alloc_if.sv
rob/rob_stail.sv
rob/rob_buffer.sv
design/dispatch_alloc.sv
design/commit_retire.sv
design/rob_top.sv
tb/rob_asserts.sv
tb/rob_tb.sv
